// ==== list.f ====
+incdir+logic
logic/cache_cpu_pkg.sv
logic/cache_mem_pkg.sv
logic/cache_sram.sv
logic/cache_tag_store.sv
logic/cache_data_array.sv
logic/cache_ctrl.sv
logic/cache_top.sv
test/cache_chk.sv
test/cache_tb.sv

// ==== logic/cache_cfg.svh ====
`ifndef CACHE_CFG_SVH
`define CACHE_CFG_SVH

// --------------------
// Cache geometry
`define CACHE_LINES         64
`define CACHE_BEATS         4   // Memory beats per line
`define CACHE_BANKS         4   // 32-bit data banks

// --------------------
// Bus widths
`define CACHE_WORD_BITS     32
`define CACHE_ADDR_BITS     30  // CPU word address
`define CACHE_BEAT_BITS     128

// Address fields from top to bottom
`define CACHE_TAG_BITS      20
`define CACHE_INDEX_BITS    6
`define CACHE_BEAT_SEL_BITS 2
`define CACHE_BANK_SEL_BITS 2

// Derived sizes
`define CACHE_ROW_BITS      (`CACHE_INDEX_BITS + `CACHE_BEAT_SEL_BITS)
`define CACHE_ROWS          (`CACHE_LINES * `CACHE_BEATS)
`define CACHE_MEM_ADDR_BITS (`CACHE_ADDR_BITS - `CACHE_BANK_SEL_BITS)
`define CACHE_MASK_BITS     (`CACHE_BEAT_BITS / 8)

`endif

// ==== logic/cache_cpu_pkg.sv ====
`include "cache_cfg.svh"

package cache_cpu_pkg;

  // --------------------
  // Address fields
  typedef logic [`CACHE_TAG_BITS-1:0]      tag_t;
  typedef logic [`CACHE_INDEX_BITS-1:0]    index_t;
  typedef logic [`CACHE_BEAT_SEL_BITS-1:0] beat_t;   // Beat within a line
  typedef logic [`CACHE_BANK_SEL_BITS-1:0] bank_t;   // Word within a beat

  // Word address as seen by the CPU
  typedef struct packed {
    tag_t   tag;
    index_t index;
    beat_t  beat;
    bank_t  bank;
  } cpu_addr_t;

  // --------------------
  // Request payload
  typedef logic [`CACHE_WORD_BITS-1:0]   cpu_word_t;
  typedef logic [`CACHE_WORD_BITS/8-1:0] cpu_strb_t;  // All zero means read

  typedef struct packed {
    cpu_addr_t addr;
    cpu_word_t data;
    cpu_strb_t strb;
  } cpu_req_t;

endpackage

// ==== logic/cache_ctrl.sv ====
`timescale 1ns/1ps
`include "cache_cfg.svh"

module cache_ctrl (
  input  logic                        clk,
  input  logic                        reset,

  // CPU side
  input  logic                        cpu_req_valid,
  output logic                        cpu_req_ready,
  input  cache_cpu_pkg::cpu_req_t     cpu_req,
  output logic                        cpu_resp_valid,

  // Tag store
  output cache_cpu_pkg::index_t       tag_index,
  output cache_cpu_pkg::tag_t         tag_tag,
  output logic                        tag_we,
  output logic                        set_dirty,
  input  logic                        hit,
  input  logic                        dirty,
  input  cache_cpu_pkg::tag_t         victim_tag,

  // Data array
  output logic [`CACHE_ROW_BITS-1:0]  row,
  output logic                        cpu_we,
  output logic                        fill_we,
  output cache_cpu_pkg::cpu_req_t     held_req,
  input  cache_mem_pkg::mem_beat_t    rd_row,

  // Memory side
  output logic                        mem_req_valid,
  input  logic                        mem_req_ready,
  output cache_mem_pkg::mem_req_t     mem_req,
  output logic                        mem_wdata_valid,
  input  logic                        mem_wdata_ready,
  output cache_mem_pkg::mem_wdata_t   mem_wdata,
  input  logic                        mem_resp_valid
);

  typedef enum logic [2:0] {
    IDLE,
    LOOKUP,      // Tag compare
    WRITE,       // Data access where writes commit
    WB_WAIT,     // Write-back beat offered
    WB,          // Next victim row read
    FETCH_WAIT,  // Fill request offered
    FETCH        // Waiting for the fill beat
  } ctrl_state_t;

  ctrl_state_t          state;
  cache_cpu_pkg::beat_t step;       // Beat counter for write-back and fill
  cache_cpu_pkg::tag_t  victim_q;   // Tag of the line being evicted
  logic                 cpu_fire;
  logic                 is_write;
  logic                 wb_fire;
  logic                 fill_beat;

  assign cpu_req_ready = (state == IDLE);
  assign cpu_fire      = cpu_req_valid && cpu_req_ready;
  assign is_write      = (held_req.strb != '0);
  assign wb_fire       = (state == WB_WAIT) && mem_req_ready && mem_wdata_ready;
  assign fill_beat     = (state == FETCH) && mem_resp_valid;

  // --------------------
  // Request hold

  always_ff @(posedge clk) begin
    if (cpu_fire) begin
      held_req <= cpu_req;
    end
  end

  // Victim tag skid held from WB_WAIT until the fill overwrites the entry
  always_ff @(posedge clk) begin
    if ((state == LOOKUP) && !hit && dirty) begin
      victim_q <= victim_tag;
    end
  end

  // --------------------
  // Tag store control

  // Index taken straight from the bus in IDLE so LOOKUP can compare
  assign tag_index = (state == IDLE) ? cpu_req.addr.index : held_req.addr.index;
  assign tag_tag   = held_req.addr.tag;

  // Entry rewritten on a write hit or on the first fill beat
  assign tag_we    = ((state == WRITE) && is_write) || (fill_beat && (step == '0));
  assign set_dirty = (state == WRITE);

  // --------------------
  // Data array control

  // Outside IDLE and WRITE the row runs one beat ahead of the memory side
  // so LOOKUP already reads victim beat 0 for a possible write-back
  always_comb begin
    if ((state == IDLE) || (state == WRITE)) begin
      row = {held_req.addr.index, held_req.addr.beat};
    end else begin
      row = {held_req.addr.index, step};
    end
  end

  assign cpu_we  = (state == WRITE) && is_write;
  assign fill_we = fill_beat;

  // --------------------
  // Memory port

  assign mem_req_valid   = (state == WB_WAIT) || (state == FETCH_WAIT);
  assign mem_req.rw      = (state == WB_WAIT);
  assign mem_req.addr    = {(state == WB_WAIT) ? victim_q : held_req.addr.tag,
                            held_req.addr.index, step};

  assign mem_wdata_valid = (state == WB_WAIT);
  assign mem_wdata.data  = rd_row;   // Row held steady while waiting
  assign mem_wdata.mask  = '1;       // Whole line written back

  // --------------------
  // State machine

  always_ff @(posedge clk) begin
    if (reset) begin
      state          <= IDLE;
      step           <= '0;
      cpu_resp_valid <= 1'b0;
    end else begin
      cpu_resp_valid <= (state == WRITE) && !is_write;  // Read data ready after WRITE

      case (state)
        IDLE: begin
          if (cpu_fire) begin
            state <= LOOKUP;
          end
        end

        LOOKUP: begin
          if (hit) begin
            state <= WRITE;
          end else if (dirty) begin
            state <= WB_WAIT;  // Evict first
          end else begin
            state <= FETCH_WAIT;
          end
        end

        WRITE: begin
          state <= IDLE;
        end

        WB_WAIT: begin
          if (wb_fire) begin
            step <= step + 1'b1;  // Wraps to 0 after the last beat
            if (step == '1) begin
              state <= FETCH_WAIT;
            end else begin
              state <= WB;
            end
          end
        end

        WB: begin
          state <= WB_WAIT;
        end

        FETCH_WAIT: begin
          if (mem_req_ready) begin
            state <= FETCH;
          end
        end

        FETCH: begin
          if (mem_resp_valid) begin
            step <= step + 1'b1;
            if (step == '1) begin
              state <= LOOKUP;  // Replay the lookup as a hit
            end else begin
              state <= FETCH_WAIT;
            end
          end
        end

        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

endmodule

// ==== logic/cache_data_array.sv ====
`timescale 1ns/1ps
`include "cache_cfg.svh"

module cache_data_array (
  input  logic                        clk,
  input  logic [`CACHE_ROW_BITS-1:0]  row,      // {index, beat}
  input  logic                        cpu_we,
  input  logic                        fill_we,
  input  cache_cpu_pkg::cpu_req_t     req,
  input  cache_mem_pkg::mem_beat_t    fill_data,
  output cache_cpu_pkg::cpu_word_t    rd_word,
  output cache_mem_pkg::mem_beat_t    rd_row
);

  cache_cpu_pkg::bank_t     rd_bank_q;
  cache_cpu_pkg::cpu_word_t bank_dout [`CACHE_BANKS];

  // --------------------
  // Banks
  // Bank b holds word b of every memory beat
  for (genvar b = 0; b < `CACHE_BANKS; b++) begin : g_bank
    logic                     bank_we;
    cache_cpu_pkg::cpu_strb_t bank_mask;
    cache_cpu_pkg::cpu_word_t bank_din;

    // CPU write touches one bank, fill touches all
    assign bank_we   = fill_we || (cpu_we && (req.addr.bank == cache_cpu_pkg::bank_t'(b)));
    assign bank_mask = fill_we ? '1 : req.strb;
    assign bank_din  = fill_we ? fill_data[b*`CACHE_WORD_BITS +: `CACHE_WORD_BITS] : req.data;

    cache_sram #(
      .DEPTH(`CACHE_ROWS),
      .WIDTH(`CACHE_WORD_BITS)
    ) u_bank (
      .clk  (clk),
      .we   (bank_we),
      .wmask(bank_mask),
      .addr (row),
      .din  (bank_din),
      .dout (bank_dout[b])
    );

    assign rd_row[b*`CACHE_WORD_BITS +: `CACHE_WORD_BITS] = bank_dout[b];
  end

  // --------------------
  // Read word select

  // Bank field sampled with the SRAM read
  always_ff @(posedge clk) begin
    rd_bank_q <= req.addr.bank;
  end

  assign rd_word = bank_dout[rd_bank_q];

endmodule

// ==== logic/cache_mem_pkg.sv ====
`include "cache_cfg.svh"

package cache_mem_pkg;

  // --------------------
  // Beat level types

  // One beat fills a row of all four banks
  typedef logic [`CACHE_BEAT_BITS-1:0] mem_beat_t;

  // Byte enables for one beat
  typedef logic [`CACHE_MASK_BITS-1:0] mem_mask_t;

  // Beat address {tag, index, beat}
  typedef logic [`CACHE_MEM_ADDR_BITS-1:0] mem_addr_t;

  // --------------------
  // Channel payloads

  // Request channel
  typedef struct packed {
    mem_addr_t addr;
    logic      rw;     // 1 for write
  } mem_req_t;

  // Write data channel raised with each write request
  typedef struct packed {
    mem_beat_t data;
    mem_mask_t mask;
  } mem_wdata_t;

endpackage

// ==== logic/cache_sram.sv ====
`timescale 1ns/1ps

// Single-port synchronous SRAM with byte write enables
module cache_sram #(
  parameter int DEPTH = 64,
  parameter int WIDTH = 32
) (
  input  logic                     clk,
  input  logic                     we,
  input  logic [WIDTH/8-1:0]       wmask,
  input  logic [$clog2(DEPTH)-1:0] addr,
  input  logic [WIDTH-1:0]         din,
  output logic [WIDTH-1:0]         dout
);

  logic [WIDTH-1:0] mem [DEPTH];

  // A write edge leaves dout holding the last read
  always_ff @(posedge clk) begin
    if (we) begin
      for (int b = 0; b < WIDTH/8; b++) begin
        if (wmask[b]) begin
          mem[addr][8*b +: 8] <= din[8*b +: 8];
        end
      end
    end else begin
      dout <= mem[addr];
    end
  end

endmodule

// ==== logic/cache_tag_store.sv ====
`timescale 1ns/1ps
`include "cache_cfg.svh"

module cache_tag_store (
  input  logic                  clk,
  input  logic                  reset,
  input  cache_cpu_pkg::index_t index,
  input  cache_cpu_pkg::tag_t   tag,
  input  logic                  we,
  input  logic                  set_dirty,
  output logic                  hit,
  output logic                  dirty,
  output cache_cpu_pkg::tag_t   stored_tag
);

  localparam int PAD_BITS = `CACHE_WORD_BITS - `CACHE_TAG_BITS - 1;

  logic [`CACHE_LINES-1:0]     valid_q;
  cache_cpu_pkg::index_t       rd_index_q;  // Line that meta_dout belongs to
  logic [`CACHE_WORD_BITS-1:0] meta_din;
  logic [`CACHE_WORD_BITS-1:0] meta_dout;
  logic                        line_valid;
  logic                        meta_dirty;

  // Entry layout {tag, dirty, pad}
  assign meta_din = {tag, set_dirty, {PAD_BITS{1'b0}}};

  cache_sram #(
    .DEPTH(`CACHE_LINES),
    .WIDTH(`CACHE_WORD_BITS)
  ) u_meta (
    .clk  (clk),
    .we   (we),
    .wmask({(`CACHE_WORD_BITS/8){1'b1}}),
    .addr (index),
    .din  (meta_din),
    .dout (meta_dout)
  );

  // Valid bits kept in flops so reset empties the cache
  always_ff @(posedge clk) begin
    if (reset) begin
      valid_q <= '0;
    end else if (we) begin
      valid_q[index] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!we) begin
      rd_index_q <= index;  // Tracks the SRAM read
    end
  end

  assign stored_tag = meta_dout[`CACHE_WORD_BITS-1 -: `CACHE_TAG_BITS];
  assign meta_dirty = meta_dout[PAD_BITS];
  assign line_valid = valid_q[rd_index_q];

  assign hit   = line_valid && (rd_index_q == index) && (stored_tag == tag);
  assign dirty = line_valid && meta_dirty;

endmodule

// ==== logic/cache_top.sv ====
`timescale 1ns/1ps
`include "cache_cfg.svh"

module cache_top (
  input  logic                        clk,
  input  logic                        reset,

  input  logic                        cpu_req_valid,
  output logic                        cpu_req_ready,
  input  cache_cpu_pkg::cpu_req_t     cpu_req,
  output logic                        cpu_resp_valid,
  output cache_cpu_pkg::cpu_word_t    cpu_resp_data,

  output logic                        mem_req_valid,
  input  logic                        mem_req_ready,
  output cache_mem_pkg::mem_req_t     mem_req,
  output logic                        mem_wdata_valid,
  input  logic                        mem_wdata_ready,
  output cache_mem_pkg::mem_wdata_t   mem_wdata,
  input  logic                        mem_resp_valid,
  input  cache_mem_pkg::mem_beat_t    mem_resp_data
);

  // --------------------
  // Internal wiring
  cache_cpu_pkg::index_t       tag_index;
  cache_cpu_pkg::tag_t         tag_tag;
  cache_cpu_pkg::tag_t         stored_tag;
  logic                        tag_we;
  logic                        set_dirty;
  logic                        hit;
  logic                        dirty;
  logic [`CACHE_ROW_BITS-1:0]  row;
  logic                        cpu_we;
  logic                        fill_we;
  cache_cpu_pkg::cpu_req_t     held_req;
  cache_mem_pkg::mem_beat_t    rd_row;

  cache_ctrl u_ctrl (
    .clk            (clk),
    .reset          (reset),
    .cpu_req_valid  (cpu_req_valid),
    .cpu_req_ready  (cpu_req_ready),
    .cpu_req        (cpu_req),
    .cpu_resp_valid (cpu_resp_valid),
    .tag_index      (tag_index),
    .tag_tag        (tag_tag),
    .tag_we         (tag_we),
    .set_dirty      (set_dirty),
    .hit            (hit),
    .dirty          (dirty),
    .victim_tag     (stored_tag),
    .row            (row),
    .cpu_we         (cpu_we),
    .fill_we        (fill_we),
    .held_req       (held_req),
    .rd_row         (rd_row),
    .mem_req_valid  (mem_req_valid),
    .mem_req_ready  (mem_req_ready),
    .mem_req        (mem_req),
    .mem_wdata_valid(mem_wdata_valid),
    .mem_wdata_ready(mem_wdata_ready),
    .mem_wdata      (mem_wdata),
    .mem_resp_valid (mem_resp_valid)
  );

  cache_tag_store u_tags (
    .clk       (clk),
    .reset     (reset),
    .index     (tag_index),
    .tag       (tag_tag),
    .we        (tag_we),
    .set_dirty (set_dirty),
    .hit       (hit),
    .dirty     (dirty),
    .stored_tag(stored_tag)
  );

  // Read word goes straight out as the response
  cache_data_array u_data (
    .clk      (clk),
    .row      (row),
    .cpu_we   (cpu_we),
    .fill_we  (fill_we),
    .req      (held_req),
    .fill_data(mem_resp_data),
    .rd_word  (cpu_resp_data),
    .rd_row   (rd_row)
  );

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build the cache testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
  --top-module cache_tb -f list.f -o cache_sim || exit 1
result=$(./obj_dir/cache_sim +verilator+error+limit+100)
echo "$result"
echo "$result" | grep -q "^Regression passed$" && exit 0 || exit 1

// ==== test/cache_chk.sv ====
`timescale 1ns/1ps

module cache_chk (
  input logic                      clk,
  input logic                      reset,
  input logic                      cpu_req_ready,
  input logic                      cpu_resp_valid,
  input logic                      mem_req_valid,
  input logic                      mem_req_ready,
  input cache_mem_pkg::mem_req_t   mem_req,
  input logic                      mem_wdata_valid,
  input logic                      mem_wdata_ready,
  input cache_mem_pkg::mem_wdata_t mem_wdata
);

  int fail_count = 0;

  // --------------------
  // Memory side
  req_hold: assert property (@(posedge clk) disable iff (reset)
    mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req))
    else begin
      fail_count++;
      $error("mem_req dropped or changed before ready");
    end

  // Write data waits for both readies
  wdata_hold: assert property (@(posedge clk) disable iff (reset)
    mem_wdata_valid && !(mem_req_ready && mem_wdata_ready)
    |=> mem_wdata_valid && $stable(mem_wdata))
    else begin
      fail_count++;
      $error("mem_wdata dropped or changed before the beat moved");
    end

  wdata_with_req: assert property (@(posedge clk) disable iff (reset)
    mem_wdata_valid |-> mem_req_valid && mem_req.rw)
    else begin
      fail_count++;
      $error("mem_wdata_valid without a write request");
    end

  // --------------------
  // CPU side
  resp_pulse: assert property (@(posedge clk) disable iff (reset)
    cpu_resp_valid |=> !cpu_resp_valid)
    else begin
      fail_count++;
      $error("cpu_resp_valid high on two cycles in a row");
    end

  ready_after_reset: assert property (@(posedge clk)
    $fell(reset) |-> cpu_req_ready)
    else begin
      fail_count++;
      $error("cpu_req_ready low in the first cycle after reset");
    end

endmodule

// ==== test/cache_tb.sv ====
`timescale 1ns/1ps
`include "cache_cfg.svh"

module cache_tb;

  localparam int NUM_TRANS       = 65;  // CPU transactions over all tests
  localparam int WATCHDOG_CYCLES = 200 * NUM_TRANS;
  localparam int RESP_DELAY      = 3;

  logic                      clk = 1'b0;
  logic                      reset;
  logic                      cpu_req_valid;
  logic                      cpu_req_ready;
  cache_cpu_pkg::cpu_req_t   cpu_req;
  logic                      cpu_resp_valid;
  cache_cpu_pkg::cpu_word_t  cpu_resp_data;
  logic                      mem_req_valid;
  logic                      mem_req_ready = 1'b0;
  cache_mem_pkg::mem_req_t   mem_req;
  logic                      mem_wdata_valid;
  logic                      mem_wdata_ready = 1'b0;
  cache_mem_pkg::mem_wdata_t mem_wdata;
  logic                      mem_resp_valid = 1'b0;
  cache_mem_pkg::mem_beat_t  mem_resp_data = '0;

  int     errors = 0;
  int     checks = 0;
  integer seed = 32'h6679_9ba4;
  logic   stall_en = 1'b0;

  cache_mem_pkg::mem_beat_t mem_store [cache_mem_pkg::mem_addr_t];  // Written beats
  cache_cpu_pkg::cpu_word_t shadow [logic [`CACHE_ADDR_BITS-1:0]];   // CPU writes
  cache_mem_pkg::mem_addr_t rd_log [$];
  cache_mem_pkg::mem_addr_t wr_log [$];
  cache_mem_pkg::mem_addr_t resp_addr;
  int                       resp_timer = 0;

  cache_top uut (.*);

  bind cache_top cache_chk u_chk (
    .clk            (clk),
    .reset          (reset),
    .cpu_req_ready  (cpu_req_ready),
    .cpu_resp_valid (cpu_resp_valid),
    .mem_req_valid  (mem_req_valid),
    .mem_req_ready  (mem_req_ready),
    .mem_req        (mem_req),
    .mem_wdata_valid(mem_wdata_valid),
    .mem_wdata_ready(mem_wdata_ready),
    .mem_wdata      (mem_wdata)
  );

  always #4 clk = ~clk;

  // --------------------
  // Expected values
  function automatic cache_cpu_pkg::cpu_word_t rule_word(
      input logic [`CACHE_ADDR_BITS-1:0] waddr);
    return {2'b00, waddr} ^ 32'h5a5a_0000;  // Unwritten memory
  endfunction

  function automatic cache_cpu_pkg::cpu_word_t expect_word(
      input logic [`CACHE_ADDR_BITS-1:0] waddr);
    if (shadow.exists(waddr)) begin
      return shadow[waddr];
    end
    return rule_word(waddr);
  endfunction

  function automatic void shadow_write(input logic [`CACHE_ADDR_BITS-1:0] waddr,
                                       input cache_cpu_pkg::cpu_word_t data,
                                       input cache_cpu_pkg::cpu_strb_t strb);
    cache_cpu_pkg::cpu_word_t word;
    word = expect_word(waddr);
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        word[8*b +: 8] = data[8*b +: 8];
      end
    end
    shadow[waddr] = word;
  endfunction

  // One beat of the line as the CPU should see it
  function automatic cache_mem_pkg::mem_beat_t shadow_beat(input cache_mem_pkg::mem_addr_t baddr);
    cache_mem_pkg::mem_beat_t beat;
    for (int k = 0; k < `CACHE_BANKS; k++) begin
      beat[32*k +: 32] = expect_word({baddr, 2'(k)});
    end
    return beat;
  endfunction

  function automatic cache_mem_pkg::mem_beat_t model_beat(input cache_mem_pkg::mem_addr_t baddr);
    cache_mem_pkg::mem_beat_t beat;
    if (mem_store.exists(baddr)) begin
      return mem_store[baddr];
    end
    for (int k = 0; k < `CACHE_BANKS; k++) begin
      beat[32*k +: 32] = rule_word({baddr, 2'(k)});
    end
    return beat;
  endfunction

  function automatic cache_cpu_pkg::cpu_addr_t make_addr(input cache_cpu_pkg::tag_t tag,
                                                         input cache_cpu_pkg::index_t index,
                                                         input cache_cpu_pkg::beat_t beat,
                                                         input cache_cpu_pkg::bank_t bank);
    cache_cpu_pkg::cpu_addr_t addr;
    addr.tag   = tag;
    addr.index = index;
    addr.beat  = beat;
    addr.bank  = bank;
    return addr;
  endfunction

  // --------------------
  // Compare tasks
  task automatic check_word(input cache_cpu_pkg::cpu_word_t got,
                            input cache_cpu_pkg::cpu_word_t exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_beat(input cache_mem_pkg::mem_beat_t got,
                            input cache_mem_pkg::mem_beat_t exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_addr(input cache_mem_pkg::mem_addr_t got,
                            input cache_mem_pkg::mem_addr_t exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic confirm(input logic cond, input string what);
    checks++;
    if (!cond) begin
      errors++;
      $display("ERROR at %0t ns: %s", $time, what);
    end
  endtask

  // Four beat addresses of one line in beat order
  task automatic check_line_addrs(input cache_mem_pkg::mem_addr_t log[$],
                                  input cache_cpu_pkg::tag_t tag,
                                  input cache_cpu_pkg::index_t index, input string what);
    confirm(log.size() == `CACHE_BEATS,
            $sformatf("%s: memory saw %0d beats instead of 4", what, log.size()));
    for (int k = 0; k < log.size() && k < `CACHE_BEATS; k++) begin
      check_addr(log[k], {tag, index, 2'(k)}, what);
    end
  endtask

  // --------------------
  // Memory model
  always @(posedge clk) begin
    logic [31:0]              r;
    cache_mem_pkg::mem_beat_t wbeat;
    if (stall_en) begin
      r = $random(seed);
      mem_req_ready   <= r[0] | r[1];
      mem_wdata_ready <= r[2] | r[3];
    end else begin
      mem_req_ready   <= 1'b1;
      mem_wdata_ready <= 1'b1;
    end

    mem_resp_valid <= 1'b0;
    if (resp_timer > 0) begin
      resp_timer <= resp_timer - 1;
      if (resp_timer == 1) begin
        mem_resp_valid <= 1'b1;
        mem_resp_data  <= model_beat(resp_addr);
      end
    end

    if (!reset && mem_req_valid && mem_req_ready) begin
      if (!mem_req.rw) begin
        rd_log.push_back(mem_req.addr);
        resp_addr  <= mem_req.addr;
        resp_timer <= RESP_DELAY;
      end else if (mem_wdata_ready) begin  // Write beat needs both readies
        wr_log.push_back(mem_req.addr);
        check_beat(mem_wdata.data, shadow_beat(mem_req.addr), "write-back data");
        confirm(mem_wdata.mask === '1, "write-back byte mask is not all ones");
        wbeat = model_beat(mem_req.addr);
        for (int b = 0; b < `CACHE_MASK_BITS; b++) begin
          if (mem_wdata.mask[b]) begin
            wbeat[8*b +: 8] = mem_wdata.data[8*b +: 8];
          end
        end
        mem_store[mem_req.addr] = wbeat;
      end
    end
  end

  // --------------------
  // CPU transactions
  task automatic cpu_access(input cache_cpu_pkg::cpu_addr_t addr,
                            input cache_cpu_pkg::cpu_word_t data,
                            input cache_cpu_pkg::cpu_strb_t strb,
                            output cache_cpu_pkg::cpu_word_t rdata, output int latency);
    cache_cpu_pkg::cpu_req_t req;
    int                      cycles;
    req.addr = addr;
    req.data = data;
    req.strb = strb;
    cycles   = 0;
    rdata    = '0;
    cpu_req_valid <= 1'b1;
    cpu_req       <= req;
    @(posedge clk);
    while (!cpu_req_ready) begin
      @(posedge clk);
    end
    cpu_req_valid <= 1'b0;  // Accepted on this edge
    do begin
      @(posedge clk);
      cycles++;
    end while ((strb == '0) ? !cpu_resp_valid : !cpu_req_ready);
    if (strb == '0) begin
      rdata = cpu_resp_data;
    end
    latency = cycles - 1;
  endtask

  task automatic do_read(input cache_cpu_pkg::cpu_addr_t addr, output int latency);
    cache_cpu_pkg::cpu_word_t got;
    cpu_access(addr, '0, '0, got, latency);
    check_word(got, expect_word(addr), "read data");
  endtask

  task automatic do_write(input cache_cpu_pkg::cpu_addr_t addr,
                          input cache_cpu_pkg::cpu_word_t data,
                          input cache_cpu_pkg::cpu_strb_t strb);
    cache_cpu_pkg::cpu_word_t ignored;
    int                       latency;
    cpu_access(addr, data, strb, ignored, latency);
    shadow_write(addr, data, strb);
  endtask

  task automatic finish_test(input string name, input int errors_before);
    $display("[%0t ns] %s finished with %0d errors", $time, name, errors - errors_before);
  endtask

  // --------------------
  // Tests
  cache_cpu_pkg::cpu_addr_t addr_a;
  cache_cpu_pkg::cpu_addr_t addr_w;

  task automatic test_reset_and_first_miss();
    int e0;
    int lat;
    e0 = errors;
    confirm(cpu_req_ready, "cpu_req_ready low after reset");
    confirm(!cpu_resp_valid && !mem_req_valid && !mem_wdata_valid, "a valid high after reset");
    rd_log.delete();
    wr_log.delete();
    do_read(addr_a, lat);
    check_line_addrs(rd_log, addr_a.tag, addr_a.index, "fetch address");
    confirm(wr_log.size() == 0, "write-back on a miss into an empty cache");
    finish_test("reset_and_first_miss", e0);
  endtask

  task automatic test_read_hit();
    int e0;
    int lat;
    e0 = errors;
    rd_log.delete();
    do_read(addr_a, lat);
    confirm(lat == 2, $sformatf("read hit answered after %0d cycles, not 2", lat));
    confirm(rd_log.size() == 0, "read hit went to memory");
    finish_test("read_hit", e0);
  endtask

  task automatic test_partial_write();
    int e0;
    int lat;
    e0 = errors;
    do_write(addr_w, 32'h1122_3344, 4'b0011);
    do_write(addr_w, 32'haabb_ccdd, 4'b1100);
    do_read(addr_w, lat);
    finish_test("partial_write", e0);
  endtask

  task automatic test_eviction();
    cache_cpu_pkg::cpu_addr_t addr_b;
    int                       e0;
    int                       lat;
    e0     = errors;
    addr_b = make_addr(20'h00077, addr_a.index, addr_a.beat, addr_a.bank);
    rd_log.delete();
    wr_log.delete();
    do_read(addr_b, lat);
    check_line_addrs(wr_log, addr_a.tag, addr_a.index, "write-back address");
    check_line_addrs(rd_log, addr_b.tag, addr_b.index, "fetch address");
    wr_log.delete();
    do_read(addr_w, lat);  // Old line back from memory
    confirm(wr_log.size() == 0, "clean line was written back");
    finish_test("eviction", e0);
  endtask

  task automatic test_stalled_misses();
    cache_cpu_pkg::cpu_addr_t p;
    cache_cpu_pkg::cpu_addr_t q;
    int                       e0;
    int                       lat;
    e0 = errors;
    stall_en <= 1'b1;
    for (int i = 0; i < 6; i++) begin
      p = make_addr(cache_cpu_pkg::tag_t'(20'h300 + i), 6'(10 + i % 2), 2'(i), 2'(3 - i % 4));
      q = make_addr(cache_cpu_pkg::tag_t'(20'h400 + i), p.index, p.beat, 2'(i));
      do_write(p, 32'hc0de_0000 + 32'(i), 4'b1111);
      do_read(q, lat);  // Dirty eviction of p
      do_read(p, lat);
    end
    stall_en <= 1'b0;
    finish_test("stalled_misses", e0);
  endtask

  task automatic test_random_mix();
    cache_cpu_pkg::cpu_addr_t addr;
    logic [31:0]              r;
    cache_cpu_pkg::cpu_word_t wdata;
    int                       e0;
    int                       lat;
    e0 = errors;
    for (int n = 0; n < 40; n++) begin
      r     = $random(seed);
      wdata = $random(seed);
      addr  = make_addr(cache_cpu_pkg::tag_t'(20'h500 + r[1:0]),
                        cache_cpu_pkg::index_t'(r[3:2]) + 6'd20, r[5:4], r[7:6]);
      if (r[8] && (r[12:9] != '0)) begin
        do_write(addr, wdata, r[12:9]);
      end else begin
        do_read(addr, lat);  // A zero mask is a read too
      end
    end
    finish_test("random_mix", e0);
  endtask

  // --------------------
  // Main sequence
  initial begin
    reset         = 1'b1;
    cpu_req_valid = 1'b0;
    cpu_req       = '0;
    addr_a        = make_addr(20'h00012, 6'd5, 2'd1, 2'd2);
    addr_w        = make_addr(20'h00012, 6'd5, 2'd1, 2'd3);
    repeat (2) @(posedge clk);
    reset <= 1'b0;
    @(posedge clk);

    test_reset_and_first_miss();
    test_read_hit();
    test_partial_write();
    test_eviction();
    test_stalled_misses();
    test_random_mix();

    $display("Summary: %0d checks, %0d errors, %0d assertion failures",
             checks, errors, uut.u_chk.fail_count);
    if (errors == 0 && uut.u_chk.fail_count == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Timeout: tests did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("Regression failed");
    $finish;
  end

endmodule
